/* design/dec_decode_ctl.sv */
// decode, load scoreboard, hazard stall, X/R/WB pipe and trace record
`timescale 1ns/1ps
`default_nettype none

module dec_decode_ctl #(
   parameter int NBLOAD_DEPTH = dec_types_pkg::NBLOAD_DEPTH_DEF   // power of two, 2..8
) (
   input  logic                             clk,
   input  logic                             rst_n,
   input  logic                             ib_valid_d,
   input  dec_types_pkg::xlen_t             ib_instr_d,
   input  dec_types_pkg::pc_t               ib_pc_d,
   input  dec_types_pkg::xlen_t             rd0,                // arf rs1 data
   input  dec_types_pkg::xlen_t             rd1,                // arf rs2 data
   input  dec_types_pkg::xlen_t             exu_i0_result_x,    // alu result in X
   input  logic                             lsu_nonblock_load_data_valid,
   input  logic [$clog2(NBLOAD_DEPTH)-1:0]  lsu_nonblock_load_data_tag,
   output logic                             dec_i0_stall_d,
   output logic                             dec_i0_decode_d,
   output logic                             dec_i0_load_d,
   output dec_types_pkg::reg_addr_t         rs1_addr,
   output dec_types_pkg::reg_addr_t         rs2_addr,
   output logic                             wen_r,
   output dec_types_pkg::reg_addr_t         waddr_r,
   output dec_types_pkg::xlen_t             wdata_r,
   output logic                             wen_ld,
   output dec_types_pkg::reg_addr_t         waddr_ld,
   output dec_types_pkg::xlen_t             gpr_i0_rs1_d,
   output dec_types_pkg::xlen_t             gpr_i0_rs2_d,
   output dec_types_pkg::xlen_t             dec_i0_immed_d,
   output logic [$clog2(NBLOAD_DEPTH)-1:0]  lsu_nonblock_load_tag_d,
   output logic                             trace_valid,
   output dec_types_pkg::xlen_t             trace_insn,
   output dec_types_pkg::xlen_t             trace_address,
   output logic                             trace_exception,
   output logic [4:0]                       trace_ecause,
   output dec_types_pkg::xlen_t             trace_tval
);

   import dec_types_pkg::*;
   import dec_isa_pkg::*;

   localparam int TAG_W = $clog2(NBLOAD_DEPTH);

   opcode_e    opc_d;
   reg_addr_t  rd_d;
   logic       legal_d;
   logic       load_d;
   logic       rs1_en_d;
   logic       rs2_en_d;
   logic       rd_en_d;      // legal with nonzero rd
   logic       x_hit_d;
   logic       ld_hit_d;

   logic [NBLOAD_DEPTH-1:0] sb_busy;
   logic [NBLOAD_DEPTH-1:0] sb_live;   // busy minus this cycle's return
   reg_addr_t               sb_rd [NBLOAD_DEPTH];
   logic                    tag_free;
   logic [TAG_W-1:0]        tag_alloc;
   logic                    pend_rs1;
   logic                    pend_rs2;
   logic                    pend_rd;

   logic       x_valid, r_valid, wb_valid;
   logic       x_wen, r_wen;
   logic       x_exc, r_exc, wb_exc;
   reg_addr_t  x_rd, r_rd;
   xlen_t      x_insn, r_insn, wb_insn;
   pc_t        x_pc, r_pc, wb_pc;
   xlen_t      r_result;

   // ****************************************
   // field and immediate decode
   // ****************************************
   assign rd_d     = ib_instr_d[RD_LSB  +: 5];
   assign rs1_addr = ib_instr_d[RS1_LSB +: 5];
   assign rs2_addr = ib_instr_d[RS2_LSB +: 5];

   always_comb begin
      opc_d          = opcode_e'(ib_instr_d[6:0]);
      legal_d        = 1'b0;
      load_d         = 1'b0;
      rs1_en_d       = 1'b0;
      rs2_en_d       = 1'b0;
      dec_i0_immed_d = '0;                           // OP has no immediate
      case (opc_d)
         OP: begin
            legal_d  = 1'b1;
            rs1_en_d = 1'b1;
            rs2_en_d = 1'b1;
         end
         OP_IMM, LOAD: begin
            legal_d        = 1'b1;
            rs1_en_d       = 1'b1;
            load_d         = (opc_d == LOAD);
            dec_i0_immed_d = {{20{ib_instr_d[31]}}, ib_instr_d[31:20]};   // I-type
         end
         LUI: begin
            legal_d        = 1'b1;
            dec_i0_immed_d = {ib_instr_d[31:12], 12'b0};                 // U-type
         end
         default: begin
            legal_d = 1'b0;   // compressed forms never match, [1:0] != 2'b11
         end
      endcase
   end

   assign rd_en_d      = legal_d & (rd_d != '0);
   assign gpr_i0_rs1_d = rs1_en_d ? rd0 : '0;
   assign gpr_i0_rs2_d = rs2_en_d ? rd1 : '0;

   // ****************************************
   // load scoreboard
   // ****************************************
   always_comb begin
      sb_live = sb_busy;
      if (lsu_nonblock_load_data_valid)
         sb_live[lsu_nonblock_load_data_tag] = 1'b0;   // readable now via write-through
   end

   always_comb begin
      tag_free  = 1'b0;
      tag_alloc = '0;
      pend_rs1  = 1'b0;
      pend_rs2  = 1'b0;
      pend_rd   = 1'b0;
      for (int t = NBLOAD_DEPTH - 1; t >= 0; t--) begin
         if (!sb_live[t]) begin
            tag_free  = 1'b1;
            tag_alloc = TAG_W'(t);                    // lowest free tag wins
         end
         pend_rs1 |= sb_live[t] & (sb_rd[t] == rs1_addr);
         pend_rs2 |= sb_live[t] & (sb_rd[t] == rs2_addr);
         pend_rd  |= sb_live[t] & (sb_rd[t] == rd_d);
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         sb_busy <= '0;
      end else begin
         sb_busy <= sb_live;
         if (dec_i0_load_d)
            sb_busy[tag_alloc] <= 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (dec_i0_load_d)
         sb_rd[tag_alloc] <= rd_d;
   end

   assign wen_ld                  = lsu_nonblock_load_data_valid & sb_busy[lsu_nonblock_load_data_tag];
   assign waddr_ld                = sb_rd[lsu_nonblock_load_data_tag];
   assign lsu_nonblock_load_tag_d = tag_alloc;

   // ****************************************
   // hazards and stall
   // ****************************************
   // x_wen already excludes x0
   assign x_hit_d  = x_valid & x_wen &
                     ((rs1_en_d & (rs1_addr == x_rd)) | (rs2_en_d & (rs2_addr == x_rd)));
   assign ld_hit_d = (rs1_en_d & (rs1_addr != '0) & pend_rs1) |
                     (rs2_en_d & (rs2_addr != '0) & pend_rs2) |
                     (rd_en_d & pend_rd);                        // waw on a pending load

   assign dec_i0_stall_d  = ib_valid_d & (x_hit_d | ld_hit_d | (load_d & ~tag_free));
   assign dec_i0_decode_d = ib_valid_d & ~dec_i0_stall_d;
   assign dec_i0_load_d   = dec_i0_decode_d & load_d;

   // ****************************************
   // X / R / WB pipe
   // ****************************************
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         x_valid  <= 1'b0;
         r_valid  <= 1'b0;
         wb_valid <= 1'b0;
      end else begin
         x_valid  <= dec_i0_decode_d;   // stall inserts a bubble
         r_valid  <= x_valid;
         wb_valid <= r_valid;
      end
   end

   always_ff @(posedge clk) begin
      x_wen    <= rd_en_d & ~load_d;     // loads write through the tag port
      x_exc    <= ~legal_d;
      x_rd     <= rd_d;
      x_insn   <= ib_instr_d;
      x_pc     <= ib_pc_d;
      r_wen    <= x_wen;
      r_exc    <= x_exc;
      r_rd     <= x_rd;
      r_result <= exu_i0_result_x;       // sampled in X
      r_insn   <= x_insn;
      r_pc     <= x_pc;
      wb_exc   <= r_exc;
      wb_insn  <= r_insn;
      wb_pc    <= r_pc;
   end

   assign wen_r   = r_valid & r_wen;
   assign waddr_r = r_rd;
   assign wdata_r = r_result;

   // trace record in WB
   assign trace_valid     = wb_valid;
   assign trace_insn      = wb_insn;
   assign trace_address   = {wb_pc, 1'b0};
   assign trace_exception = wb_valid & wb_exc;
   assign trace_ecause    = trace_exception ? ECAUSE_ILLEGAL : 5'd0;
   assign trace_tval      = trace_exception ? wb_insn : '0;   // faulting instruction word

endmodule

`default_nettype wire

/* design/dec_gpr_ctl.sv */
// architectural register file with two read and two write ports
`timescale 1ns/1ps
`default_nettype none

module dec_gpr_ctl (
   input  logic                      clk,
   input  logic                      rst_n,
   input  dec_types_pkg::reg_addr_t  rs1_addr,   // read port 0
   input  dec_types_pkg::reg_addr_t  rs2_addr,   // read port 1
   input  logic                      wen_r,      // alu writeback at R
   input  dec_types_pkg::reg_addr_t  waddr_r,
   input  dec_types_pkg::xlen_t      wdata_r,
   input  logic                      wen_ld,     // load return port
   input  dec_types_pkg::reg_addr_t  waddr_ld,
   input  dec_types_pkg::xlen_t      wdata_ld,
   output dec_types_pkg::xlen_t      rd0,
   output dec_types_pkg::xlen_t      rd1
);

   import dec_types_pkg::*;

   xlen_t regs [1:31];   // x0 has no storage

   // ****************************************
   // write, load port wins on equal address
   // ****************************************
   always_ff @(posedge clk) begin
      for (int i = 1; i < 32; i++) begin
         if (!rst_n) begin
            regs[i] <= '0;
         end else if (wen_ld && (waddr_ld == reg_addr_t'(i))) begin
            regs[i] <= wdata_ld;
         end else if (wen_r && (waddr_r == reg_addr_t'(i))) begin
            regs[i] <= wdata_r;
         end
      end
   end

   // ****************************************
   // read with write-through
   // ****************************************
   function automatic xlen_t arf_read(input reg_addr_t a);
      xlen_t d;
      d = '0;                                     // x0 reads zero
      if (a != '0) begin
         if (wen_ld && (waddr_ld == a))
            d = wdata_ld;                         // same priority as the write
         else if (wen_r && (waddr_r == a))
            d = wdata_r;
         else
            d = regs[a];
      end
      return d;
   endfunction

   always_comb begin
      rd0 = arf_read(rs1_addr);
      rd1 = arf_read(rs2_addr);
   end

endmodule

`default_nettype wire

/* design/dec_ib_ctl.sv */
// instruction buffer capturing the fetched instruction into D
`timescale 1ns/1ps
`default_nettype none

module dec_ib_ctl (
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic                 ifu_i0_valid,     // fetch presents an instruction
   input  dec_types_pkg::xlen_t ifu_i0_instr,     // held by fetch under stall
   input  dec_types_pkg::pc_t   ifu_i0_pc,
   input  logic                 dec_i0_stall_d,   // decode cannot take D
   output logic                 ib_valid_d,       // D holds an instruction
   output dec_types_pkg::xlen_t ib_instr_d,
   output dec_types_pkg::pc_t   ib_pc_d
);

   logic ib_load;   // buffer takes new contents this edge

   // empty slot, or the held instruction leaves D this cycle
   assign ib_load = ~ib_valid_d | ~dec_i0_stall_d;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         ib_valid_d <= 1'b0;
      end else if (ib_load) begin
         ib_valid_d <= ifu_i0_valid;   // bubble when fetch is idle
      end
   end

   // payload only moves with a real instruction
   always_ff @(posedge clk) begin
      if (ib_load && ifu_i0_valid) begin
         ib_instr_d <= ifu_i0_instr;
         ib_pc_d    <= ifu_i0_pc;
      end
   end

endmodule

`default_nettype wire

/* design/dec_isa_pkg.sv */
// opcode enum, instruction field positions and exception cause code
`default_nettype none

package dec_isa_pkg;

   // ****************************************
   // supported major opcodes
   // ****************************************
   typedef enum logic [6:0] {
      OP     = 7'b0110011,   // reg-reg alu
      OP_IMM = 7'b0010011,   // reg-imm alu
      LUI    = 7'b0110111,   // upper immediate
      LOAD   = 7'b0000011    // non-blocking load
   } opcode_e;

   // ****************************************
   // register field lsb positions
   // ****************************************
   localparam int RD_LSB  = 7;    // rd  [11:7]
   localparam int RS1_LSB = 15;   // rs1 [19:15]
   localparam int RS2_LSB = 20;   // rs2 [24:20]

   // mcause encoding for an illegal instruction
   localparam logic [4:0] ECAUSE_ILLEGAL = 5'd2;

endpackage

`default_nettype wire

/* design/dec_top.sv */
// decode slice top connecting instruction buffer, register file and decode
`timescale 1ns/1ps
`default_nettype none

module dec_top (
   input  logic                        clk,
   input  logic                        rst_n,
   input  logic                        ifu_i0_valid,
   input  dec_types_pkg::xlen_t        ifu_i0_instr,
   input  dec_types_pkg::pc_t          ifu_i0_pc,
   input  dec_types_pkg::xlen_t        exu_i0_result_x,
   input  logic                        lsu_nonblock_load_data_valid,
   input  dec_types_pkg::nbload_tag_t  lsu_nonblock_load_data_tag,
   input  dec_types_pkg::xlen_t        lsu_nonblock_load_data,
   output logic                        dec_i0_stall_d,      // to fetch
   output logic                        dec_i0_decode_d,
   output logic                        dec_i0_load_d,       // to lsu
   output dec_types_pkg::xlen_t        gpr_i0_rs1_d,
   output dec_types_pkg::xlen_t        gpr_i0_rs2_d,
   output dec_types_pkg::xlen_t        dec_i0_immed_d,
   output dec_types_pkg::nbload_tag_t  lsu_nonblock_load_tag_d,
   output logic                        trace_valid,
   output dec_types_pkg::xlen_t        trace_insn,
   output dec_types_pkg::xlen_t        trace_address,
   output logic                        trace_exception,
   output logic [4:0]                  trace_ecause,
   output dec_types_pkg::xlen_t        trace_tval
);

   import dec_types_pkg::*;

   localparam int NBLOAD_DEPTH = NBLOAD_DEPTH_DEF;   // loads in flight

   // buffer to decode
   logic       ib_valid_d;
   xlen_t      ib_instr_d;
   pc_t        ib_pc_d;

   // decode to arf
   reg_addr_t  rs1_addr;
   reg_addr_t  rs2_addr;
   logic       wen_r;
   reg_addr_t  waddr_r;
   xlen_t      wdata_r;
   logic       wen_ld;
   reg_addr_t  waddr_ld;
   xlen_t      rd0;
   xlen_t      rd1;

   // ****************************************
   // instances
   // ****************************************
   dec_ib_ctl ib_ctl_i (.*);

   dec_gpr_ctl gpr_ctl_i (
      .*,
      .wdata_ld (lsu_nonblock_load_data)   // load data straight from the lsu
   );

   dec_decode_ctl #(
      .NBLOAD_DEPTH (NBLOAD_DEPTH)
   ) decode_ctl_i (.*);

endmodule

`default_nettype wire

/* design/dec_types_pkg.sv */
// datapath width typedefs and load tag sizing
`default_nettype none

package dec_types_pkg;

   // ****************************************
   // data and address widths
   // ****************************************
   typedef logic [31:0] xlen_t;       // architectural data word
   typedef logic [31:1] pc_t;         // halfword pc, bit 0 implied zero
   typedef logic [4:0]  reg_addr_t;   // gpr index x0..x31

   // ****************************************
   // non-blocking loads
   // ****************************************
   parameter int NBLOAD_DEPTH_DEF = 4;   // loads in flight by default

   typedef logic [$clog2(NBLOAD_DEPTH_DEF)-1:0] nbload_tag_t;   // lsu tag at default depth

endpackage

`default_nettype wire

/* project.f */
design/dec_types_pkg.sv
design/dec_isa_pkg.sv
design/dec_ib_ctl.sv
design/dec_gpr_ctl.sv
design/dec_decode_ctl.sv
design/dec_top.sv
test/dec_tb_sva.sv
test/dec_tb.sv

/* run.sh */
#!/bin/sh
# build and run the decode slice testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f project.f --top-module dec_tb -o dec_sim

./obj_dir/dec_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST FAIL" sim.log; then
   exit 1
fi
if ! grep -q "TEST PASS" sim.log; then
   exit 1
fi
exit 0

/* test/dec_tb.sv */
// directed testbench for dec_top with reference register model and trace queue
`timescale 1ns/1ps
`default_nettype none

module dec_tb;

   import dec_types_pkg::*;
   import dec_isa_pkg::*;

   logic        clk, rst_n;
   logic        ifu_i0_valid;
   xlen_t       ifu_i0_instr;
   pc_t         ifu_i0_pc;
   xlen_t       exu_i0_result_x;
   logic        lsu_nonblock_load_data_valid;
   nbload_tag_t lsu_nonblock_load_data_tag;
   xlen_t       lsu_nonblock_load_data;
   logic        dec_i0_stall_d, dec_i0_decode_d, dec_i0_load_d;
   xlen_t       gpr_i0_rs1_d, gpr_i0_rs2_d, dec_i0_immed_d;
   nbload_tag_t lsu_nonblock_load_tag_d;
   logic        trace_valid, trace_exception;
   xlen_t       trace_insn, trace_address, trace_tval;
   logic [4:0]  trace_ecause;

   xlen_t       ref_regs [32];                    // architectural reference
   logic [NBLOAD_DEPTH_DEF-1:0] ld_busy;          // reference scoreboard
   reg_addr_t   ld_rd [NBLOAD_DEPTH_DEF];
   xlen_t       iq_insn [$];                      // issued, not yet decoded
   xlen_t       iq_pc [$];
   xlen_t       tq_insn [$];                      // expected trace records
   xlen_t       tq_pc [$];
   logic        tq_exc [$];
   xlen_t       pc, exu_next;
   int          errors, nchecks, stall_cnt;

   dec_top dut_i (.*);

   always #5 clk = ~clk;
   always @(negedge clk) exu_i0_result_x = exu_next;   // alu result lands in X

   task automatic check_value(input string name, input xlen_t got, input xlen_t exp);
      nchecks++;
      if (got !== exp) begin
         errors++;
         $display("** Error at %0d ns: %s = %h, expected %h", $time, name, got, exp);
      end
   endtask

   task automatic timeout(input string what);
      errors++;
      $display("timeout: %s did not happen in time", what);
   endtask

   function automatic xlen_t enc_i(input logic [6:0] opc, input int rd, input int rs1,
                                   input logic [11:0] imm);
      return {imm, 5'(rs1), 3'b000, 5'(rd), opc};
   endfunction

   function automatic xlen_t enc_r(input int rd, input int rs1, input int rs2);
      return {7'b0, 5'(rs2), 5'(rs1), 3'b000, 5'(rd), 7'(OP)};
   endfunction

   // ****************************************
   // decode and trace monitor
   // ****************************************
   always @(posedge clk) begin
      xlen_t ins, ipc, imm, res;
      logic [6:0] opc;
      logic legal, found;
      int t;
      if (rst_n && dec_i0_decode_d) begin
         ins = iq_insn.pop_front();
         ipc = iq_pc.pop_front();
         opc = ins[6:0];
         legal = (opc == OP) || (opc == OP_IMM) || (opc == LUI) || (opc == LOAD);
         imm = 32'b0;                                           // OP and illegal
         if (opc == OP_IMM || opc == LOAD) imm = $signed(ins) >>> 20;   // sign filled
         if (opc == LUI) imm = ins & 32'hffff_f000;                     // low 12 cleared
         check_value("dec_i0_immed_d", dec_i0_immed_d, imm);
         if (legal && opc != LUI) check_value("gpr_i0_rs1_d", gpr_i0_rs1_d, ref_regs[ins[19:15]]);
         if (opc == OP) check_value("gpr_i0_rs2_d", gpr_i0_rs2_d, ref_regs[ins[24:20]]);
         res = (opc == LUI) ? imm : $urandom;
         check_value("dec_i0_load_d", 32'(dec_i0_load_d), 32'(opc == LOAD));
         if (opc == LOAD) begin
            found = 1'b0;
            for (t = 0; t < NBLOAD_DEPTH_DEF && !found; t++) begin
               if (!ld_busy[t]) begin                           // lowest free tag
                  found = 1'b1;
                  check_value("lsu_nonblock_load_tag_d", 32'(lsu_nonblock_load_tag_d), t);
                  ld_busy[t] = 1'b1;
                  ld_rd[t] = ins[11:7];
               end
            end
            if (!found) begin
               errors++;
               $display("load decoded at %0d ns with every tag busy", $time);
            end
         end else if (legal && ins[11:7] != 5'd0) begin
            ref_regs[ins[11:7]] = res;
         end
         exu_next = res;
         tq_insn.push_back(ins);
         tq_pc.push_back(ipc);
         tq_exc.push_back(!legal);
      end
      if (dec_i0_stall_d) stall_cnt++;
      if (rst_n && trace_valid) begin
         if (tq_insn.size() == 0) begin
            errors++;
            $display("unexpected trace record at %0d ns", $time);
         end else begin
            ins = tq_insn.pop_front();
            ipc = tq_pc.pop_front();
            legal = !tq_exc.pop_front();
            check_value("trace_insn", trace_insn, ins);
            check_value("trace_address", trace_address, ipc);
            check_value("trace_exception", 32'(trace_exception), 32'(!legal));
            check_value("trace_ecause", 32'(trace_ecause), legal ? 32'd0 : 32'(ECAUSE_ILLEGAL));
            check_value("trace_tval", trace_tval, legal ? 32'd0 : ins);
         end
      end
   end

   // ****************************************
   // stimulus tasks
   // ****************************************
   task automatic drive_instr(input xlen_t ins);
      int n;
      @(negedge clk);
      ifu_i0_valid = 1'b1;
      ifu_i0_instr = ins;
      ifu_i0_pc    = pc[31:1];
      iq_insn.push_back(ins);
      iq_pc.push_back(pc);
      pc += 4;
      #1;
      n = 0;
      while (dec_i0_stall_d && n < 50) begin   // fetch holds while stalled
         @(negedge clk);
         #1;
         n++;
      end
      if (dec_i0_stall_d) timeout("fetch acceptance");
      @(posedge clk);
   endtask

   task automatic fetch_idle();
      @(negedge clk);
      ifu_i0_valid = 1'b0;
   endtask

   task automatic return_load(input int rd);
      int t, hit;
      hit = -1;
      for (t = 0; t < NBLOAD_DEPTH_DEF; t++)
         if (ld_busy[t] && ld_rd[t] == 5'(rd)) hit = t;
      @(negedge clk);
      if (hit < 0) begin
         errors++;
         $display("no load in flight for x%0d", rd);
      end else begin
         lsu_nonblock_load_data_valid = 1'b1;
         lsu_nonblock_load_data_tag   = nbload_tag_t'(hit);
         lsu_nonblock_load_data       = $urandom;
         if (rd != 0) ref_regs[rd] = lsu_nonblock_load_data;
         ld_busy[hit] = 1'b0;
         @(negedge clk);
         lsu_nonblock_load_data_valid = 1'b0;
      end
   endtask

   task automatic drain();
      int n;
      fetch_idle();
      n = 0;
      while ((iq_insn.size() != 0 || tq_insn.size() != 0) && n < 100) begin
         @(negedge clk);
         n++;
      end
      if (iq_insn.size() != 0 || tq_insn.size() != 0) timeout("pipeline drain");
   endtask

   task automatic expect_stall();
      repeat (3) @(negedge clk);
      #1;
      check_value("dec_i0_stall_d", 32'(dec_i0_stall_d), 32'd1);
   endtask

   // ****************************************
   // directed tests
   // ****************************************
   task automatic test_reset_alu();
      for (int i = 1; i < 32; i++) drive_instr(enc_r(0, i, i));   // all zero
      drive_instr(enc_i(OP_IMM, 3, 0, 12'h123));
      drive_instr(enc_r(0, 3, 0));
      drive_instr(enc_i(OP_IMM, 0, 3, 12'h001));                 // x0 write ignored
      drive_instr(enc_r(0, 0, 3));
      drain();
   endtask

   task automatic test_immediates();
      drive_instr(enc_i(OP_IMM, 4, 3, 12'h800));
      drive_instr(enc_i(OP_IMM, 4, 3, 12'h7ff));
      drive_instr({20'habcde, 5'd2, 7'(LUI)});
      drive_instr(enc_r(1, 2, 4));
      drain();
   endtask

   task automatic test_trace();
      drive_instr(enc_i(7'b1111111, 9, 1, 12'h055));             // illegal opcode
      drive_instr(32'h0000_4485);                               // compressed form
      drive_instr(enc_r(0, 9, 2));
      drain();
   endtask

   task automatic test_ooo_loads();
      for (int i = 10; i < 14; i++) drive_instr(enc_i(LOAD, i, 0, 12'(i)));
      drive_instr(enc_i(LOAD, 14, 0, 12'h040));
      fetch_idle();
      expect_stall();                                            // all tags busy
      for (int i = 13; i >= 10; i--) return_load(i);
      drain();
      return_load(14);
      drive_instr(enc_r(0, 10, 11));
      drive_instr(enc_r(0, 12, 13));
      drive_instr(enc_r(0, 14, 0));
      drain();
   endtask

   task automatic test_hazards();
      drive_instr(enc_i(LOAD, 5, 0, 12'h010));
      drive_instr(enc_i(OP_IMM, 8, 5, 12'h001));                 // load-use
      fetch_idle();
      expect_stall();
      return_load(5);
      drain();
      stall_cnt = 0;
      drive_instr(enc_i(OP_IMM, 6, 0, 12'h00f));
      drive_instr(enc_i(OP_IMM, 7, 6, 12'h002));                 // reads x6 from X
      drain();
      check_value("stall cycles", stall_cnt, 1);
   endtask

   initial begin
      int e0;
      void'($urandom(32'h1187bd05));
      clk = 1'b0;
      rst_n = 1'b0;
      ifu_i0_valid = 1'b0;
      ifu_i0_instr = '0;
      ifu_i0_pc = '0;
      exu_i0_result_x = '0;
      lsu_nonblock_load_data_valid = 1'b0;
      lsu_nonblock_load_data_tag = '0;
      lsu_nonblock_load_data = '0;
      for (int i = 0; i < 32; i++) ref_regs[i] = '0;
      ld_busy = '0;
      pc = 32'h0000_1000;
      exu_next = '0;
      errors = 0;
      nchecks = 0;
      stall_cnt = 0;
      repeat (3) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
      e0 = errors;
      test_reset_alu();
      $display("reset_alu finished, %0d errors", errors - e0);
      e0 = errors;
      test_immediates();
      $display("immediates finished, %0d errors", errors - e0);
      e0 = errors;
      test_trace();
      $display("trace finished, %0d errors", errors - e0);
      e0 = errors;
      test_ooo_loads();
      $display("ooo_loads finished, %0d errors", errors - e0);
      e0 = errors;
      test_hazards();
      $display("hazards finished, %0d errors", errors - e0);
      $display("checks %0d, errors %0d", nchecks, errors);
      if (errors == 0)
         $display("TEST PASS");
      else
         $display("TEST FAIL");
      $finish;
   end

endmodule

`default_nettype wire

/* test/dec_tb_sva.sv */
// bound assertions on stall, trace and load scoreboard tags
`timescale 1ns/1ps
`default_nettype none

module dec_sva #(
   parameter int NBLOAD_DEPTH = dec_types_pkg::NBLOAD_DEPTH_DEF
) (
   input logic                            clk,
   input logic                            rst_n,
   input logic                            ib_valid_d,
   input dec_types_pkg::xlen_t            ib_instr_d,
   input logic                            dec_i0_stall_d,
   input logic                            dec_i0_decode_d,
   input logic                            trace_valid,
   input logic                            trace_exception,
   input dec_types_pkg::xlen_t            trace_insn,
   input logic                            lsu_nonblock_load_data_valid,
   input logic [$clog2(NBLOAD_DEPTH)-1:0] lsu_nonblock_load_data_tag,
   input logic [NBLOAD_DEPTH-1:0]         sb_busy,
   input dec_types_pkg::reg_addr_t        sb_rd [NBLOAD_DEPTH]
);

   import dec_isa_pkg::*;

   logic dup_rd;   // two live loads share a destination

   always_comb begin
      dup_rd = 1'b0;
      for (int i = 0; i < NBLOAD_DEPTH; i++)
         for (int j = i + 1; j < NBLOAD_DEPTH; j++)
            if (sb_busy[i] && sb_busy[j] && sb_rd[i] == sb_rd[j] && sb_rd[i] != 5'd0)
               dup_rd = 1'b1;
   end

   // a stalled instruction is not consumed, it is still in D next cycle
   a_no_decode_in_stall: assert property (@(posedge clk) disable iff (!rst_n)
      dec_i0_stall_d |=> ib_valid_d && $stable(ib_instr_d))
      else $error("stalled instruction left D");

   a_exc_has_valid: assert property (@(posedge clk) disable iff (!rst_n)
      trace_exception |-> trace_valid && !(trace_insn[6:0] inside {OP, OP_IMM, LUI, LOAD}))
      else $error("exception without trace_valid or on a legal opcode");

   a_ret_tag_busy: assert property (@(posedge clk) disable iff (!rst_n)
      lsu_nonblock_load_data_valid |-> sb_busy[lsu_nonblock_load_data_tag])
      else $error("returned tag was free");

   a_unique_rd: assert property (@(posedge clk) disable iff (!rst_n) !dup_rd)
      else $error("busy tags share a destination");

endmodule

bind dec_decode_ctl dec_sva #(.NBLOAD_DEPTH(NBLOAD_DEPTH)) sva_i (
   .clk                          (clk),
   .rst_n                        (rst_n),
   .ib_valid_d                   (ib_valid_d),
   .ib_instr_d                   (ib_instr_d),
   .dec_i0_stall_d               (dec_i0_stall_d),
   .dec_i0_decode_d              (dec_i0_decode_d),
   .trace_valid                  (trace_valid),
   .trace_exception              (trace_exception),
   .trace_insn                   (trace_insn),
   .lsu_nonblock_load_data_valid (lsu_nonblock_load_data_valid),
   .lsu_nonblock_load_data_tag   (lsu_nonblock_load_data_tag),
   .sb_busy                      (sb_busy),
   .sb_rd                        (sb_rd)
);

`default_nettype wire
